// File: md_core.f
+incdir+include
verilog/md_core_pkg.sv
verilog/md_host_regs.sv
verilog/md_pad_mapper.sv
verilog/md_cart_mem.sv
verilog/md_video_out.sv
verilog/md_core_top.sv
verif/md_core_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module md_core_tb -f md_core.f --Mdir obj_dir -o md_core_sim
	./obj_dir/md_core_sim | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/md_core_tb.sv
/*
 * Mega Drive glue core testbench
 * Directed tests for ROM loading, save RAM, cartridge back-pressure,
 * pad mapping and video formatting
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_defines.svh"

module md_core_tb;

    logic                                   clk_74a;
    logic                                   reset_n;
    logic [`MD_BRIDGE_AW-1:0]               bridge_addr_i;
    logic                                   bridge_wr_i;
    logic [`MD_BRIDGE_DW-1:0]               bridge_wr_data_i;
    logic                                   bridge_rd_i;
    wire  [`MD_BRIDGE_DW-1:0]               bridge_rd_data_o;
    logic                                   dataslot_write_i;
    logic                                   dataslot_done_i;
    logic [`MD_PLAYERS-1:0][`MD_KEY_W-1:0]  cont_key_i;
    md_core_pkg::md_pad_t [`MD_PLAYERS-1:0] pad_o;
    logic                                   cart_req_i;
    md_core_pkg::md_cart_cmd_t              cart_cmd_i;
    wire                                    cart_ack_o;
    wire  [15:0]                            cart_rdata_o;
    md_core_pkg::md_vdp_pix_t               pix_i;
    md_core_pkg::md_video_t                 video_o;

    logic [31:0]           rng_state;
    logic [31:0]           rom_words [8];
    logic [`MD_ROM_AW-1:0] rom_entry [8];

    // Scaler level per 4-bit console level
    localparam logic [7:0] color_level [16] = '{
        8'd0,   8'd27,  8'd49,  8'd71,  8'd87,  8'd103, 8'd119, 8'd130,
        8'd146, 8'd157, 8'd174, 8'd190, 8'd206, 8'd228, 8'd255, 8'd255
    };

    md_core_top dut0 (
        .clk_74a          (clk_74a),
        .reset_n          (reset_n),
        .bridge_addr_i    (bridge_addr_i),
        .bridge_wr_i      (bridge_wr_i),
        .bridge_wr_data_i (bridge_wr_data_i),
        .bridge_rd_i      (bridge_rd_i),
        .bridge_rd_data_o (bridge_rd_data_o),
        .dataslot_write_i (dataslot_write_i),
        .dataslot_done_i  (dataslot_done_i),
        .cont_key_i       (cont_key_i),
        .pad_o            (pad_o),
        .cart_req_i       (cart_req_i),
        .cart_cmd_i       (cart_cmd_i),
        .cart_ack_o       (cart_ack_o),
        .cart_rdata_o     (cart_rdata_o),
        .pix_i            (pix_i),
        .video_o          (video_o)
    );

    always #20 clk_74a = ~clk_74a;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Z Y X mode start B C A up down left right
    function automatic logic [11:0] expected_pad(input logic [15:0] key);
        return {key[9], key[6], key[8], key[14], key[15], key[4],
                key[5], key[7], key[0], key[1], key[2], key[3]};
    endfunction

    function automatic logic [23:0] colour_of(input logic [11:0] rgb4);
        return {color_level[rgb4[11:8]], color_level[rgb4[7:4]], color_level[rgb4[3:0]]};
    endfunction

    function automatic logic [23:0] mode_word(input md_core_pkg::md_res_e res);
        return {11'(res), 13'd0};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("Error at %0t: %s", $time, reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic wait_ack(input logic level, input int limit);
        int n;
        n = 0;
        while ((cart_ack_o !== level) && (n < limit)) begin
            @(negedge clk_74a);
            n++;
        end
        if (cart_ack_o !== level) begin
            fail_run($sformatf("cartridge ack did not go to %0d in time", level));
        end
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_addr_i    = addr;
        bridge_wr_data_i = data;
        bridge_wr_i      = 1'b1;
        @(negedge clk_74a);
        bridge_wr_i      = 1'b0;
    endtask

    // Read data settles two cycles after the strobe
    task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
        bridge_addr_i = addr;
        bridge_rd_i   = 1'b1;
        @(negedge clk_74a);
        bridge_rd_i   = 1'b0;
        @(negedge clk_74a);
        data = bridge_rd_data_o;
    endtask

    task automatic pulse_dataslot(input logic done);
        dataslot_write_i = ~done;
        dataslot_done_i  = done;
        @(negedge clk_74a);
        dataslot_write_i = 1'b0;
        dataslot_done_i  = 1'b0;
        check_value("download", {31'd0, dut0.u_host_regs.download_o}, {31'd0, ~done});
    endtask

    task automatic cart_access(input logic [22:0] addr, input logic we, input logic [1:0] be,
                               input logic [15:0] wdata, output logic [15:0] rdata);
        cart_cmd_i.addr  = addr;
        cart_cmd_i.we    = we;
        cart_cmd_i.ube   = be[1];
        cart_cmd_i.lbe   = be[0];
        cart_cmd_i.wdata = wdata;
        cart_req_i       = 1'b1;
        wait_ack(1'b1, 20);
        rdata      = cart_rdata_o;
        cart_req_i = 1'b0;
        wait_ack(1'b0, 20);
    endtask

    // Idle cycle that follows carries the inverted pixel with pix_ce low
    task automatic send_pixel(input logic [11:0] rgb4, input logic hsync, input logic vsync,
                              input logic hblank, input logic vblank,
                              input md_core_pkg::md_res_e res);
        pix_i.pix_ce = 1'b1;
        pix_i.r      = rgb4[11:8];
        pix_i.g      = rgb4[7:4];
        pix_i.b      = rgb4[3:0];
        pix_i.hsync  = hsync;
        pix_i.vsync  = vsync;
        pix_i.hblank = hblank;
        pix_i.vblank = vblank;
        pix_i.res    = res;
        @(negedge clk_74a);
        pix_i        = md_core_pkg::md_vdp_pix_t'(~pix_i);
        pix_i.pix_ce = 1'b0;
    endtask

    // Outputs must also hold through the idle cycle
    task automatic check_video(input logic de, input logic hs, input logic vs,
                               input logic [23:0] rgb);
        for (int pass = 0; pass < 2; pass++) begin
            check_value("video_o.de", {31'd0, video_o.de}, {31'd0, de});
            check_value("video_o.hs", {31'd0, video_o.hs}, {31'd0, hs});
            check_value("video_o.vs", {31'd0, video_o.vs}, {31'd0, vs});
            check_value("video_o.rgb", {8'd0, video_o.rgb}, {8'd0, rgb});
            if (pass == 0) begin
                @(negedge clk_74a);
            end
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic rom_load_read();
        logic [15:0] rdata;
        pulse_dataslot(1'b0);
        for (int i = 0; i < 8; i++) begin
            rom_entry[i] = 10'(i * 131 + 3);
            rom_words[i] = rand_word();
            bridge_write({`MD_ROM_REGION, 16'd0, rom_entry[i], 2'b00}, rom_words[i]);
        end
        pulse_dataslot(1'b1);
        for (int i = 0; i < 8; i++) begin
            cart_access({3'd0, 9'd0, rom_entry[i], 1'b0}, 1'b0, 2'b00, 16'h0000, rdata);
            check_value("cart_rdata_o even", {16'd0, rdata}, {16'd0, rom_words[i][31:16]});
            // Any window other than save maps to ROM
            cart_access({3'd5, 9'd0, rom_entry[i], 1'b1}, 1'b0, 2'b00, 16'h0000, rdata);
            check_value("cart_rdata_o odd", {16'd0, rdata}, {16'd0, rom_words[i][15:0]});
        end
        // Cartridge writes leave ROM alone
        cart_access({3'd0, 9'd0, rom_entry[0], 1'b0}, 1'b1, 2'b11, 16'hdead, rdata);
        cart_access({3'd0, 9'd0, rom_entry[0], 1'b0}, 1'b0, 2'b00, 16'h0000, rdata);
        check_value("cart_rdata_o rom", {16'd0, rdata}, {16'd0, rom_words[0][31:16]});
    endtask

    task automatic save_ram_both_sides();
        logic [31:0] r;
        logic [31:0] rd;
        logic [15:0] rdata;
        logic [15:0] merged;
        r = rand_word();
        bridge_write({`MD_SAVE_REGION, 17'd0, 10'h2a5, 1'b0}, r);
        cart_access({`MD_SAVE_WINDOW, 10'd0, 10'h2a5}, 1'b0, 2'b00, 16'h0000, rdata);
        check_value("cart_rdata_o save", {16'd0, rdata}, {16'd0, r[15:0]});
        merged = r[15:0];
        // Low byte only, then high byte only
        r = rand_word();
        cart_access({`MD_SAVE_WINDOW, 10'd0, 10'h2a5}, 1'b1, 2'b01, r[15:0], rdata);
        merged = {merged[15:8], r[7:0]};
        bridge_read({`MD_SAVE_REGION, 17'd0, 10'h2a5, 1'b0}, rd);
        check_value("bridge_rd_data_o", rd, {16'd0, merged});
        r = rand_word();
        cart_access({`MD_SAVE_WINDOW, 10'd0, 10'h2a5}, 1'b1, 2'b10, r[15:0], rdata);
        merged = {r[15:8], merged[7:0]};
        bridge_read({`MD_SAVE_REGION, 17'd0, 10'h2a5, 1'b0}, rd);
        check_value("bridge_rd_data_o", rd, {16'd0, merged});
        bridge_read(32'h3000_0040, rd);
        check_value("bridge_rd_data_o unmapped", rd, 32'd0);
    endtask

    task automatic back_pressure();
        pulse_dataslot(1'b0);
        cart_cmd_i.addr  = {3'd0, 9'd0, rom_entry[5], 1'b1};
        cart_cmd_i.we    = 1'b0;
        cart_cmd_i.ube   = 1'b0;
        cart_cmd_i.lbe   = 1'b0;
        cart_cmd_i.wdata = 16'h0000;
        cart_req_i       = 1'b1;
        repeat (20) begin
            @(negedge clk_74a);
            check_value("cart_ack_o", {31'd0, cart_ack_o}, 32'd0);
        end
        pulse_dataslot(1'b1);
        wait_ack(1'b1, 20);
        check_value("cart_rdata_o", {16'd0, cart_rdata_o}, {16'd0, rom_words[5][15:0]});
        cart_req_i = 1'b0;
        wait_ack(1'b0, 20);
    endtask

    task automatic pad_mapping();
        logic [31:0] r;
        logic        tap;
        logic [11:0] expected;
        tap = 1'b0;
        for (int round = 0; round < 6; round++) begin
            if (round == 2) begin
                bridge_write(`MD_MULTITAP_ADDR, 32'd1);
                tap = 1'b1;
            end
            if (round == 4) begin
                bridge_write(`MD_MULTITAP_ADDR, 32'd0);
                tap = 1'b0;
            end
            for (int p = 0; p < `MD_PLAYERS; p++) begin
                r = rand_word();
                cont_key_i[p] = r[15:0];
            end
            @(negedge clk_74a);
            for (int p = 0; p < `MD_PLAYERS; p++) begin
                expected = ((p < 2) || tap) ? expected_pad(cont_key_i[p]) : 12'd0;
                check_value($sformatf("pad_o[%0d]", p), {20'd0, pad_o[p]}, {20'd0, expected});
            end
        end
    endtask

    task automatic video_formatting();
        md_core_pkg::md_res_e modes [4];
        md_core_pkg::md_res_e m;
        logic [31:0]          r;
        modes = '{md_core_pkg::RES_256X224, md_core_pkg::RES_320X224,
                  md_core_pkg::RES_256X240, md_core_pkg::RES_320X240};
        m = md_core_pkg::RES_256X240;
        for (int i = 0; i < 8; i++) begin
            r = rand_word();
            send_pixel(r[11:0], 1'b0, 1'b0, 1'b0, 1'b0, m);
            check_video(1'b1, 1'b0, 1'b0, colour_of(r[11:0]));
        end
        for (int k = 0; k < 4; k++) begin
            r = rand_word();
            send_pixel(r[11:0], 1'b0, 1'b0, 1'b1, 1'b0, modes[k]);
            check_video(1'b0, 1'b0, 1'b0, mode_word(modes[k]));
        end
        // Single pulses on rising syncs
        send_pixel(r[11:0], 1'b1, 1'b0, 1'b1, 1'b0, m);
        check_video(1'b0, 1'b1, 1'b0, mode_word(m));
        send_pixel(r[11:0], 1'b1, 1'b0, 1'b1, 1'b0, m);
        check_video(1'b0, 1'b0, 1'b0, mode_word(m));
        send_pixel(r[11:0], 1'b0, 1'b1, 1'b1, 1'b0, m);
        check_video(1'b0, 1'b0, 1'b1, mode_word(m));
        send_pixel(r[11:0], 1'b0, 1'b1, 1'b1, 1'b0, m);
        check_video(1'b0, 1'b0, 1'b0, mode_word(m));
        send_pixel(r[11:0], 1'b0, 1'b0, 1'b1, 1'b0, m);
        check_video(1'b0, 1'b0, 1'b0, mode_word(m));
        // Line starting inside vblank stays blank to its end
        send_pixel(r[11:0], 1'b1, 1'b0, 1'b1, 1'b1, m);
        check_video(1'b0, 1'b1, 1'b0, mode_word(m));
        for (int i = 0; i < 3; i++) begin
            r = rand_word();
            send_pixel(r[11:0], 1'b0, 1'b0, 1'b0, 1'b1, m);
            check_video(1'b0, 1'b0, 1'b0, mode_word(m));
        end
        send_pixel(r[11:0], 1'b0, 1'b0, 1'b0, 1'b0, m);
        check_video(1'b0, 1'b0, 1'b0, mode_word(m));
        send_pixel(r[11:0], 1'b1, 1'b0, 1'b1, 1'b0, m);
        check_video(1'b0, 1'b1, 1'b0, mode_word(m));
        r = rand_word();
        send_pixel(r[11:0], 1'b0, 1'b0, 1'b0, 1'b0, m);
        check_video(1'b1, 1'b0, 1'b0, colour_of(r[11:0]));
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        clk_74a          = 1'b0;
        reset_n          = 1'b0;
        bridge_addr_i    = '0;
        bridge_wr_i      = 1'b0;
        bridge_wr_data_i = '0;
        bridge_rd_i      = 1'b0;
        dataslot_write_i = 1'b0;
        dataslot_done_i  = 1'b0;
        cont_key_i       = '0;
        cart_req_i       = 1'b0;
        cart_cmd_i       = '0;
        pix_i            = '0;
        rng_state        = 32'hf168_f6db;
        repeat (2) @(negedge clk_74a);
        reset_n = 1'b1;
        check_value("cart_ack_o", {31'd0, cart_ack_o}, 32'd0);
        check_value("bridge_rd_data_o", bridge_rd_data_o, 32'd0);
        check_value("pad_o", {31'd0, |pad_o}, 32'd0);
        check_value("video_o flags", {29'd0, video_o.de, video_o.hs, video_o.vs}, 32'd0);
        check_value("multitap and download",
                    {30'd0, dut0.u_host_regs.multitap_o, dut0.u_host_regs.download_o}, 32'd0);
        rom_load_read();
        save_ram_both_sides();
        back_pressure();
        pad_mapping();
        video_formatting();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/md_core_top.sv
/*
 * Mega Drive glue core top level
 * Bridge decode, controller mapping, cartridge memories and video
 * formatting on one clock
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_defines.svh"

module md_core_top (
    input  wire                                     clk_74a,
    input  wire                                     reset_n,
    // Host bridge
    input  wire  [`MD_BRIDGE_AW-1:0]                bridge_addr_i,
    input  wire                                     bridge_wr_i,
    input  wire  [`MD_BRIDGE_DW-1:0]                bridge_wr_data_i,
    input  wire                                     bridge_rd_i,
    output wire  [`MD_BRIDGE_DW-1:0]                bridge_rd_data_o,
    input  wire                                     dataslot_write_i,
    input  wire                                     dataslot_done_i,
    // Controllers
    input  wire  [`MD_PLAYERS-1:0][`MD_KEY_W-1:0]   cont_key_i,
    output md_core_pkg::md_pad_t [`MD_PLAYERS-1:0]  pad_o,
    // Cartridge bus
    input  wire                                     cart_req_i,
    input  wire  md_core_pkg::md_cart_cmd_t         cart_cmd_i,
    output wire                                     cart_ack_o,
    output wire  [15:0]                             cart_rdata_o,
    // Video
    input  wire  md_core_pkg::md_vdp_pix_t          pix_i,
    output md_core_pkg::md_video_t                  video_o
);

    wire                          multitap;
    wire                          download;
    wire [15:0]                   save_rd_data;
    md_core_pkg::md_rom_cmd_t     rom_cmd;
    md_core_pkg::md_save_cmd_t    save_cmd;

    ////////////////////////////////////////
    // Bridge side
    ////////////////////////////////////////

    md_host_regs u_host_regs (
        .clk_74a          (clk_74a),
        .reset_n          (reset_n),
        .bridge_addr_i    (bridge_addr_i),
        .bridge_wr_i      (bridge_wr_i),
        .bridge_wr_data_i (bridge_wr_data_i),
        .bridge_rd_i      (bridge_rd_i),
        .dataslot_write_i (dataslot_write_i),
        .dataslot_done_i  (dataslot_done_i),
        .save_rd_data_i   (save_rd_data),
        .bridge_rd_data_o (bridge_rd_data_o),
        .multitap_o       (multitap),
        .download_o       (download),
        .rom_cmd_o        (rom_cmd),
        .save_cmd_o       (save_cmd)
    );

    md_pad_mapper u_pad_mapper (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .multitap_i (multitap),
        .cont_key_i (cont_key_i),
        .pad_o      (pad_o)
    );

    ////////////////////////////////////////
    // Console side
    ////////////////////////////////////////

    md_cart_mem u_cart_mem (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .download_i     (download),
        .rom_cmd_i      (rom_cmd),
        .save_cmd_i     (save_cmd),
        .cart_req_i     (cart_req_i),
        .cart_cmd_i     (cart_cmd_i),
        .save_rd_data_o (save_rd_data),
        .cart_ack_o     (cart_ack_o),
        .cart_rdata_o   (cart_rdata_o)
    );

    md_video_out u_video_out (
        .clk_74a (clk_74a),
        .reset_n (reset_n),
        .pix_i   (pix_i),
        .video_o (video_o)
    );

endmodule

`default_nettype wire

// File: verilog/md_video_out.sv
/*
 * Video output formatting
 * Console pixel stream to scaler format with colour expansion,
 * sync edge pulses, per-line vblank and the blanking mode word
 */
`timescale 1ns/1ps
`default_nettype none

module md_video_out (
    input  wire                          clk_74a,
    input  wire                          reset_n,
    input  wire  md_core_pkg::md_vdp_pix_t  pix_i,
    output md_core_pkg::md_video_t       video_o
);

    logic        hsync_prev;
    logic        vsync_prev;
    logic        vblank_line;
    logic        hs_rise;
    logic        vs_rise;
    logic        active;
    logic        de_q;
    logic        hs_q;
    logic        vs_q;
    logic [23:0] rgb_q;

    // Edges judged against the previous enabled pixel
    assign hs_rise = pix_i.hsync && !hsync_prev;
    assign vs_rise = pix_i.vsync && !vsync_prev;
    assign active  = !(pix_i.hblank || vblank_line);

    ////////////////////////////////////////
    // Sync and enable
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            hsync_prev  <= 1'b0;
            vsync_prev  <= 1'b0;
            vblank_line <= 1'b0;
            de_q        <= 1'b0;
            hs_q        <= 1'b0;
            vs_q        <= 1'b0;
        end else if (pix_i.pix_ce) begin
            hsync_prev <= pix_i.hsync;
            vsync_prev <= pix_i.vsync;
            hs_q       <= hs_rise;
            vs_q       <= vs_rise;
            de_q       <= active;
            // Whole line follows vblank as seen at its hsync
            if (hs_rise) begin
                vblank_line <= pix_i.vblank;
            end
        end
    end

    ////////////////////////////////////////
    // Colour and mode word
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (pix_i.pix_ce) begin
            if (active) begin
                rgb_q <= {md_core_pkg::md_color_levels[pix_i.r],
                          md_core_pkg::md_color_levels[pix_i.g],
                          md_core_pkg::md_color_levels[pix_i.b]};
            end else begin
                // Scaler slot index in the upper 11 bits
                rgb_q <= {9'd0, pix_i.res, 13'd0};
            end
        end
    end

    assign video_o.rgb = rgb_q;
    assign video_o.de  = de_q;
    assign video_o.hs  = hs_q;
    assign video_o.vs  = vs_q;

endmodule

`default_nettype wire

// File: verilog/md_cart_mem.sv
/*
 * Cartridge memories
 * On-chip ROM and two-port save RAM behind a four-phase req/ack
 * cartridge bus, with requests held off during ROM download
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_defines.svh"

module md_cart_mem (
    input  wire                          clk_74a,
    input  wire                          reset_n,
    input  wire                          download_i,
    input  wire  md_core_pkg::md_rom_cmd_t  rom_cmd_i,
    input  wire  md_core_pkg::md_save_cmd_t save_cmd_i,
    input  wire                          cart_req_i,
    input  wire  md_core_pkg::md_cart_cmd_t cart_cmd_i,
    output logic [15:0]                  save_rd_data_o,
    output logic                         cart_ack_o,
    output logic [15:0]                  cart_rdata_o
);

    logic [31:0] rom_mem  [2**`MD_ROM_AW];
    logic [15:0] save_mem [2**`MD_SAVE_AW];

    md_core_pkg::md_cart_state_e state;

    logic                   cart_access;
    logic                   in_save;
    logic [`MD_ROM_AW-1:0]  rom_idx;
    logic [`MD_SAVE_AW-1:0] save_idx;
    logic [31:0]            rom_q;
    logic [15:0]            save_q;

    assign cart_access = (state == md_core_pkg::CART_ACCESS);
    assign in_save     = (cart_cmd_i.addr[`MD_CART_AW-1 -: 3] == `MD_SAVE_WINDOW);
    assign rom_idx     = cart_cmd_i.addr[`MD_ROM_AW:1];
    assign save_idx    = cart_cmd_i.addr[`MD_SAVE_AW-1:0];

    ////////////////////////////////////////
    // Memories
    ////////////////////////////////////////

    // ROM is written by the loader only, cartridge writes are dropped
    always_ff @(posedge clk_74a) begin
        if (rom_cmd_i.wr) begin
            rom_mem[rom_cmd_i.addr] <= rom_cmd_i.data;
        end
        if (cart_access) begin
            rom_q <= rom_mem[rom_idx];
        end
    end

    always_ff @(posedge clk_74a) begin
        if (save_cmd_i.wr) begin
            save_mem[save_cmd_i.addr] <= save_cmd_i.data;
        end
        if (save_cmd_i.rd) begin
            save_rd_data_o <= save_mem[save_cmd_i.addr];
        end
        if (cart_access && in_save && cart_cmd_i.we) begin
            if (cart_cmd_i.ube) begin
                save_mem[save_idx][15:8] <= cart_cmd_i.wdata[15:8];
            end
            if (cart_cmd_i.lbe) begin
                save_mem[save_idx][7:0] <= cart_cmd_i.wdata[7:0];
            end
        end
        if (cart_access) begin
            save_q <= save_mem[save_idx];
        end
    end

    ////////////////////////////////////////
    // Four-phase handshake
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            state      <= md_core_pkg::CART_IDLE;
            cart_ack_o <= 1'b0;
        end else begin
            case (state)
                md_core_pkg::CART_IDLE: begin
                    // Loader owns the memories during download
                    if (cart_req_i && !download_i) begin
                        state <= md_core_pkg::CART_ACCESS;
                    end
                end
                md_core_pkg::CART_ACCESS: begin
                    state <= md_core_pkg::CART_DONE;
                end
                md_core_pkg::CART_DONE: begin
                    if (!cart_ack_o) begin
                        cart_ack_o <= 1'b1;
                    end else if (!cart_req_i) begin
                        cart_ack_o <= 1'b0;
                        state      <= md_core_pkg::CART_IDLE;
                    end
                end
                default: state <= md_core_pkg::CART_IDLE;
            endcase
        end
    end

    // Big-endian entries, even word is the upper half
    always_ff @(posedge clk_74a) begin
        if ((state == md_core_pkg::CART_DONE) && !cart_ack_o) begin
            if (in_save) begin
                cart_rdata_o <= save_q;
            end else begin
                cart_rdata_o <= cart_cmd_i.addr[0] ? rom_q[15:0] : rom_q[31:16];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/md_pad_mapper.sv
/*
 * Controller mapping
 * Host key words reordered into registered Genesis 12-button pads
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_defines.svh"

module md_pad_mapper (
    input  wire                                     clk_74a,
    input  wire                                     reset_n,
    input  wire                                     multitap_i,
    input  wire  [`MD_PLAYERS-1:0][`MD_KEY_W-1:0]   cont_key_i,
    output md_core_pkg::md_pad_t [`MD_PLAYERS-1:0]  pad_o
);

    // Players beyond this need the multitap adapter
    localparam int BASE_PLAYERS = 2;

    function automatic md_core_pkg::md_pad_t map_keys(input logic [`MD_KEY_W-1:0] key);
        md_core_pkg::md_pad_t pad;
        pad.z     = key[9];
        pad.y     = key[6];
        pad.x     = key[8];
        pad.mode  = key[14];
        pad.start = key[15];
        pad.b     = key[4];
        pad.c     = key[5];
        pad.a     = key[7];
        // Host d-pad sits in the low nibble
        pad.up    = key[0];
        pad.down  = key[1];
        pad.left  = key[2];
        pad.right = key[3];
        return pad;
    endfunction

    ////////////////////////////////////////
    // Pad registers
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            pad_o <= '0;
        end else begin
            for (int p = 0; p < `MD_PLAYERS; p++) begin
                if ((p < BASE_PLAYERS) || multitap_i) begin
                    pad_o[p] <= map_keys(cont_key_i[p]);
                end else begin
                    // Released
                    pad_o[p] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/md_host_regs.sv
/*
 * Host bridge decode
 * Multitap and download registers, ROM and save commands from bridge
 * strobes, registered read-data mux
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_defines.svh"

module md_host_regs (
    input  wire                          clk_74a,
    input  wire                          reset_n,
    input  wire  [`MD_BRIDGE_AW-1:0]     bridge_addr_i,
    input  wire                          bridge_wr_i,
    input  wire  [`MD_BRIDGE_DW-1:0]     bridge_wr_data_i,
    input  wire                          bridge_rd_i,
    input  wire                          dataslot_write_i,
    input  wire                          dataslot_done_i,
    input  wire  [15:0]                  save_rd_data_i,
    output logic [`MD_BRIDGE_DW-1:0]     bridge_rd_data_o,
    output logic                         multitap_o,
    output logic                         download_o,
    output md_core_pkg::md_rom_cmd_t     rom_cmd_o,
    output md_core_pkg::md_save_cmd_t    save_cmd_o
);

    typedef enum logic {
        RD_OTHER,
        RD_SAVE
    } rd_region_e;

    logic [3:0]  region;
    logic        in_save;
    logic        rd_pend;
    rd_region_e  rd_region;

    assign region  = bridge_addr_i[`MD_BRIDGE_AW-1 -: 4];
    assign in_save = (region == `MD_SAVE_REGION);

    // ROM loading only while a data slot is in flight
    assign rom_cmd_o.wr   = bridge_wr_i && (region == `MD_ROM_REGION) && download_o;
    assign rom_cmd_o.addr = bridge_addr_i[`MD_ROM_AW+1:2];
    assign rom_cmd_o.data = bridge_wr_data_i;

    assign save_cmd_o.wr   = bridge_wr_i && in_save;
    assign save_cmd_o.rd   = bridge_rd_i && in_save;
    assign save_cmd_o.addr = bridge_addr_i[`MD_SAVE_AW:1];
    assign save_cmd_o.data = bridge_wr_data_i[15:0];

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            multitap_o       <= 1'b0;
            download_o       <= 1'b0;
            rd_pend          <= 1'b0;
            rd_region        <= RD_OTHER;
            bridge_rd_data_o <= '0;
        end else begin
            if (bridge_wr_i && (bridge_addr_i == `MD_MULTITAP_ADDR)) begin
                multitap_o <= bridge_wr_data_i[0];
            end
            if (dataslot_write_i) begin
                download_o <= 1'b1;
            end else if (dataslot_done_i) begin
                download_o <= 1'b0;
            end
            // Save RAM answers one cycle after the strobe
            rd_pend <= bridge_rd_i;
            if (bridge_rd_i) begin
                rd_region <= in_save ? RD_SAVE : RD_OTHER;
            end
            if (rd_pend) begin
                bridge_rd_data_o <= (rd_region == RD_SAVE) ? {16'h0000, save_rd_data_i} : '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/md_core_pkg.sv
/*
 * Mega Drive glue core types
 * Bus structs, state and resolution enums and the colour level table
 */
`default_nettype none

`include "md_core_defines.svh"

package md_core_pkg;

    // One Genesis pad, a set bit means pressed
    typedef struct packed {
        logic z;
        logic y;
        logic x;
        logic mode;
        logic start;
        logic b;
        logic c;
        logic a;
        logic up;
        logic down;
        logic left;
        logic right;
    } md_pad_t;

    typedef struct packed {
        logic [`MD_CART_AW-1:0] addr;
        logic                   we;
        logic                   ube;
        logic                   lbe;
        logic [15:0]            wdata;
    } md_cart_cmd_t;

    // Save RAM access from the bridge side
    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [`MD_SAVE_AW-1:0] addr;
        logic [15:0]            data;
    } md_save_cmd_t;

    typedef struct packed {
        logic                   wr;
        logic [`MD_ROM_AW-1:0]  addr;
        logic [31:0]            data;
    } md_rom_cmd_t;

    typedef enum logic [1:0] {
        RES_256X224,
        RES_320X224,
        RES_256X240,
        RES_320X240
    } md_res_e;

    typedef struct packed {
        logic        pix_ce;
        logic [3:0]  r;
        logic [3:0]  g;
        logic [3:0]  b;
        logic        hsync;
        logic        vsync;
        logic        hblank;
        logic        vblank;
        md_res_e     res;
    } md_vdp_pix_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } md_video_t;

    typedef enum logic [1:0] {
        CART_IDLE,
        CART_ACCESS,
        CART_DONE
    } md_cart_state_e;

    // 4-bit console level to 8-bit scaler level
    localparam logic [7:0] md_color_levels [16] = '{
        8'd0,   8'd27,  8'd49,  8'd71,
        8'd87,  8'd103, 8'd119, 8'd130,
        8'd146, 8'd157, 8'd174, 8'd190,
        8'd206, 8'd228, 8'd255, 8'd255
    };

endpackage

`default_nettype wire

// File: include/md_core_defines.svh
/*
 * Mega Drive glue core constants
 * Bridge regions, on-chip memory sizes, bus widths and the
 * cartridge save window shared by RTL and testbench
 */
`ifndef MD_CORE_DEFINES_SVH
`define MD_CORE_DEFINES_SVH

////////////////////////////////////////
// Host bridge
////////////////////////////////////////

`define MD_BRIDGE_AW      32
`define MD_BRIDGE_DW      32

// Top address nibbles of the bridge regions
`define MD_ROM_REGION     4'h1
`define MD_SAVE_REGION    4'h6
`define MD_MULTITAP_ADDR  32'h0000_0000

////////////////////////////////////////
// Memories and cartridge bus
////////////////////////////////////////

// ROM in 32-bit entries, save RAM in 16-bit words
`define MD_ROM_AW         10
`define MD_SAVE_AW        10
`define MD_CART_AW        23

// Top three cartridge address bits that select save RAM
`define MD_SAVE_WINDOW    3'd1

// Controllers
`define MD_PLAYERS        4
`define MD_KEY_W          16

`endif
